// ==== list.f ====
vec_pkg.sv
vaddsub.sv
vec_regfile.sv
vec_ctrl.sv
vec_elem_counter.sv
vec_unit_top.sv
vec_unit_asserts.sv
tb_vec_unit.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the vector unit testbench with Verilator
cd "$(dirname "$0")" || exit 1

LOG=sim.log

if ! verilator --binary --timing --assert --top-module tb_vec_unit -f list.f --Mdir obj_dir; then
  echo "Build failed"
  exit 1
fi

./obj_dir/Vtb_vec_unit > "$LOG" 2>&1
status=$?
cat "$LOG"

if grep -q "Simulation failed" "$LOG"; then
  echo "Result: FAIL"
  exit 1
fi
if [ "$status" -ne 0 ]; then
  echo "Simulator exited with status $status"
  exit 1
fi
echo "Result: PASS"

// ==== tb_vec_unit.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_vec_unit
  import vec_pkg::*;
;

  localparam int VLEN = 8;
  localparam int APB_TIMEOUT = 16;
  localparam int DONE_TIMEOUT = 100;

  logic     CLK;
  logic     nRST;
  apb_req_t apb_req;
  apb_rsp_t apb_rsp;

  logic [31:0] rng_state = 32'hc70;
  logic [15:0] a_val [VLEN];
  logic [15:0] b_val [VLEN];

  // Pending comparisons for the checking process
  string     chk_name_q [$];
  apb_data_t chk_exp_q [$];
  apb_data_t chk_act_q [$];
  string     cmp_name;
  apb_data_t cmp_exp, cmp_act;

  vec_unit_top #(.VLEN(VLEN)) vec_unit_top_inst (
    .CLK(CLK), .nRST(nRST), .apb_req(apb_req), .apb_rsp(apb_rsp)
  );

  initial CLK = 1'b0;
  always #5 CLK = ~CLK;

  task automatic abort_run();
    $display("Simulation failed");
    $fatal(1, "Run stopped after the first error");
  endtask

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  // Random normal number with its exponent kept below 30
  task automatic gen_normal(output logic [15:0] v);
    rng_state = xorshift32(rng_state);
    v = {rng_state[0], 5'(1 + (int'(rng_state[20:16]) % 29)), rng_state[13:4]};
  endtask

  // fp16 a+b or a-b computed exactly on a 2^-24 grid and then rounded
  function automatic logic [15:0] fp16_add_ref(input logic [15:0] a, input logic [15:0] b,
                                               input logic sub, output logic ovf);
    logic   sa, sb, sr;
    int     ea, eb, p, sh, er;
    longint va, vb, s, mag, sig, rem, half;
    ovf = 1'b0;
    sa  = a[15];
    sb  = b[15] ^ sub;
    ea  = int'(a[14:10]);
    eb  = int'(b[14:10]);
    if (((ea == 31) && (a[9:0] != 0)) || ((eb == 31) && (b[9:0] != 0))) return 16'h7e00;
    if ((ea == 31) && (eb == 31)) return (sa != sb) ? 16'h7e00 : {sa, 15'h7c00};
    if (ea == 31) return {sa, 15'h7c00};
    if (eb == 31) return {sb, 15'h7c00};
    // Subnormal inputs count as zero
    va = (ea == 0) ? 64'sd0 : (longint'(1024 + int'(a[9:0])) << (ea - 1));
    vb = (eb == 0) ? 64'sd0 : (longint'(1024 + int'(b[9:0])) << (eb - 1));
    s  = (sa ? -va : va) + (sb ? -vb : vb);
    if (s == 0) return 16'h0000;
    sr  = s < 0;
    mag = sr ? -s : s;
    p   = 0;
    for (int i = 0; i < 48; i++) begin
      if (mag[i]) p = i;
    end
    if (p > 10) begin
      sh   = p - 10;
      sig  = mag >> sh;
      rem  = mag & ((64'sd1 << sh) - 64'sd1);
      half = 64'sd1 << (sh - 1);
      if ((rem > half) || ((rem == half) && sig[0])) sig = sig + 1;
    end else begin
      sig = mag << (10 - p);
    end
    er = p - 9;
    if (sig == 2048) begin
      sig = 1024;
      er  = er + 1;
    end
    if (er <= 0) return 16'h0000;
    if (er >= 31) begin
      ovf = 1'b1;
      return {sr, 15'h7c00};
    end
    return {sr, er[4:0], sig[9:0]};
  endfunction

  task automatic expect_equal(input string name, input apb_data_t exp, input apb_data_t act);
    chk_name_q.push_back(name);
    chk_exp_q.push_back(exp);
    chk_act_q.push_back(act);
  endtask

  always @(negedge CLK) begin
    while (chk_exp_q.size() != 0) begin
      cmp_name = chk_name_q.pop_front();
      cmp_exp  = chk_exp_q.pop_front();
      cmp_act  = chk_act_q.pop_front();
      assert (cmp_act === cmp_exp)
        else begin
          $display("[ERROR] %s: expected %h, actual %h", cmp_name, cmp_exp, cmp_act);
          abort_run();
        end
    end
  end

  // Setup phase, access phase, then wait for pready
  task automatic apb_access(input logic wr, input apb_addr_t addr, input apb_data_t wdata,
                            output apb_data_t rdata, output logic slverr);
    int cycles;
    @(posedge CLK);
    apb_req.psel    <= 1'b1;
    apb_req.penable <= 1'b0;
    apb_req.pwrite  <= wr;
    apb_req.paddr   <= addr;
    apb_req.pwdata  <= wdata;
    @(posedge CLK);
    apb_req.penable <= 1'b1;
    cycles = 0;
    @(negedge CLK);
    while (!apb_rsp.pready) begin
      cycles++;
      if (cycles > APB_TIMEOUT) begin
        $display("Timeout: pready stayed low on an APB access");
        abort_run();
      end
      @(negedge CLK);
    end
    rdata  = apb_rsp.prdata;
    slverr = apb_rsp.pslverr;
    @(posedge CLK);
    apb_req.psel    <= 1'b0;
    apb_req.penable <= 1'b0;
    apb_req.pwrite  <= 1'b0;
  endtask

  task automatic load_vectors(input string name);
    apb_data_t rd;
    logic      err;
    for (int i = 0; i < VLEN; i++) begin
      apb_access(1'b1, apb_addr_t'(ADDR_A_BASE + 4 * i), {16'h0, a_val[i]}, rd, err);
      expect_equal({name, " A write pslverr"}, 32'h0, apb_data_t'(err));
      apb_access(1'b1, apb_addr_t'(ADDR_B_BASE + 4 * i), {16'h0, b_val[i]}, rd, err);
      expect_equal({name, " B write pslverr"}, 32'h0, apb_data_t'(err));
    end
  endtask

  task automatic start_op(input logic sub);
    apb_data_t rd;
    logic      err;
    apb_access(1'b1, ADDR_CTRL, {30'd0, sub, 1'b1}, rd, err);
    expect_equal("start pslverr", 32'h0, apb_data_t'(err));
  endtask

  task automatic wait_done();
    apb_data_t rd;
    logic      err;
    int        polls;
    polls = 0;
    apb_access(1'b0, ADDR_STATUS, '0, rd, err);
    while (!rd[1]) begin
      polls++;
      if (polls > DONE_TIMEOUT) begin
        $display("Timeout: done bit never set in STATUS");
        abort_run();
      end
      apb_access(1'b0, ADDR_STATUS, '0, rd, err);
    end
  endtask

  task automatic check_results(input string name, input logic sub);
    apb_data_t   rd;
    logic        err, ovf_lane, ovf_exp;
    logic [15:0] exp_v;
    ovf_exp = 1'b0;
    for (int i = 0; i < VLEN; i++) begin
      exp_v   = fp16_add_ref(a_val[i], b_val[i], sub, ovf_lane);
      ovf_exp = ovf_exp | ovf_lane;
      apb_access(1'b0, apb_addr_t'(ADDR_C_BASE + 4 * i), '0, rd, err);
      expect_equal($sformatf("%s C[%0d]", name, i), {16'h0, exp_v}, rd);
    end
    apb_access(1'b0, ADDR_STATUS, '0, rd, err);
    expect_equal({name, " overflow"}, apb_data_t'(ovf_exp), apb_data_t'(rd[2]));
  endtask

  initial begin
    apb_data_t rd;
    logic      err;
    int        waits;
    apb_req = '0;
    nRST    = 1'b0;
    repeat (4) @(posedge CLK);
    nRST <= 1'b1;
    @(posedge CLK);

    // Register access
    apb_access(1'b0, ADDR_STATUS, '0, rd, err);
    expect_equal("reset status", 32'h0, rd);
    for (int i = 0; i < VLEN; i++) begin
      rng_state = xorshift32(rng_state);
      a_val[i]  = rng_state[15:0];
      b_val[i]  = rng_state[31:16];
    end
    load_vectors("regs");
    for (int i = 0; i < VLEN; i++) begin
      apb_access(1'b0, apb_addr_t'(ADDR_A_BASE + 4 * i), '0, rd, err);
      expect_equal($sformatf("regs A[%0d]", i), {16'h0, a_val[i]}, rd);
      apb_access(1'b0, apb_addr_t'(ADDR_B_BASE + 4 * i), '0, rd, err);
      expect_equal($sformatf("regs B[%0d]", i), {16'h0, b_val[i]}, rd);
    end

    // Addition of random normals
    for (int i = 0; i < VLEN; i++) begin
      gen_normal(a_val[i]);
      gen_normal(b_val[i]);
    end
    load_vectors("add");
    start_op(1'b0);
    wait_done();
    check_results("add", 1'b0);

    // Subtraction where two lanes cancel exactly
    for (int i = 0; i < VLEN; i++) begin
      gen_normal(a_val[i]);
      gen_normal(b_val[i]);
    end
    b_val[0] = a_val[0];
    b_val[5] = a_val[5];
    load_vectors("sub");
    start_op(1'b1);
    wait_done();
    check_results("sub", 1'b1);

    // NaN, infinities, DAZ, FTZ and overflow
    a_val = '{16'h7c01, 16'h7c00, 16'hfc00, 16'h0001, 16'h0401, 16'h7bff, 16'hfbff, 16'h03ff};
    b_val = '{16'h3c00, 16'hfc00, 16'h4000, 16'h3c00, 16'h8400, 16'h7bff, 16'hfbff, 16'h8001};
    load_vectors("special");
    start_op(1'b0);
    wait_done();
    check_results("special", 1'b0);
    apb_access(1'b0, ADDR_STATUS, '0, rd, err);
    expect_equal("special overflow set", 32'h1, apb_data_t'(rd[2]));

    // Refused accesses leave state alone
    apb_access(1'b1, ADDR_C_BASE, 32'h1234, rd, err);
    expect_equal("write C pslverr", 32'h1, apb_data_t'(err));
    apb_access(1'b0, ADDR_C_BASE, '0, rd, err);
    expect_equal("write C unchanged", 32'h7e00, rd);
    apb_access(1'b1, ADDR_STATUS, 32'h0, rd, err);
    expect_equal("write STATUS pslverr", 32'h1, apb_data_t'(err));
    apb_access(1'b0, ADDR_STATUS, '0, rd, err);
    expect_equal("write STATUS unchanged", 32'h6, rd);
    apb_access(1'b1, 8'h08, 32'hffff, rd, err);
    expect_equal("unmapped pslverr", 32'h1, apb_data_t'(err));
    apb_access(1'b1, apb_addr_t'(ADDR_A_BASE + 4 * VLEN), 32'h1111, rd, err);
    expect_equal("lane 8 pslverr", 32'h1, apb_data_t'(err));
    apb_access(1'b0, ADDR_A_BASE, '0, rd, err);
    expect_equal("lane 8 unchanged", {16'h0, a_val[0]}, rd);

    // Second start with writes refused while busy
    for (int i = 0; i < VLEN; i++) begin
      gen_normal(a_val[i]);
      gen_normal(b_val[i]);
    end
    load_vectors("restart");
    start_op(1'b0);
    apb_access(1'b1, ADDR_A_BASE, 32'h5555, rd, err);
    expect_equal("busy A write pslverr", 32'h1, apb_data_t'(err));
    apb_access(1'b1, ADDR_CTRL, 32'h3, rd, err);
    expect_equal("busy CTRL write pslverr", 32'h1, apb_data_t'(err));
    apb_access(1'b0, ADDR_STATUS, '0, rd, err);
    expect_equal("restart clears done and overflow", 32'h0, apb_data_t'(rd[2:1]));
    wait_done();
    check_results("restart", 1'b0);
    apb_access(1'b0, ADDR_A_BASE, '0, rd, err);
    expect_equal("busy A unchanged", {16'h0, a_val[0]}, rd);
    apb_access(1'b0, ADDR_CTRL, '0, rd, err);
    expect_equal("busy CTRL unchanged", 32'h0, rd);

    waits = 0;
    while (chk_exp_q.size() != 0) begin
      waits++;
      if (waits > 10) begin
        $display("Timeout: pending checks were never compared");
        abort_run();
      end
      @(posedge CLK);
    end
    $display("Simulation passed");
    $finish;
  end

endmodule

`default_nettype wire

// ==== vaddsub.sv ====
`timescale 1ns/1ps
`default_nettype none

module vaddsub
  import vec_pkg::*;
(
  input  logic  CLK,
  input  logic  nRST,
  input  logic  in_valid,
  input  fp16_t op_a,
  input  fp16_t op_b,
  input  logic  op_sub,
  output logic  out_valid,
  output fp16_t result,
  output logic  overflow
);

  localparam int SIG_W = $bits(sig_t);
  localparam int GRS_W = 3;
  localparam int EXT_W = SIG_W + GRS_W;
  localparam int SUM_W = EXT_W + 1;

  // Canonical quiet NaN
  localparam fp16_t QNAN = 16'h7e00;

  function automatic fp16_t inf_of(input logic sign);
    return fp16_t'({sign, 5'h1f, 10'h000});
  endfunction

  // Leading zeros of a nonzero aligned magnitude
  function automatic logic [3:0] lzc(input logic [EXT_W-1:0] x);
    logic [3:0] cnt;
    logic       found;
    cnt   = 4'd0;
    found = 1'b0;
    for (int i = EXT_W - 1; i >= 0; i--) begin
      if (!found && x[i]) begin
        cnt   = 4'(EXT_W - 1 - i);
        found = 1'b1;
      end
    end
    return cnt;
  endfunction

  logic             sign_a, sign_b, eff_sub;
  logic             nan_a, nan_b, inf_a, inf_b;
  sig_t             m_a, m_b;
  logic             swap;
  exp_t             e_big, e_small, e_diff;
  logic [EXT_W-1:0] x_big, x_small, x_shift, x_align;
  logic             sticky;
  logic             s1n_special;
  fp16_t            s1n_special_res;
  logic [SUM_W-1:0] s1n_mag;

  logic             s1_valid;
  logic             s1_special;
  fp16_t            s1_special_res;
  logic [SUM_W-1:0] s1_mag;
  exp_t             s1_exp;
  logic             s1_sign;

  logic [3:0]       lz;
  logic [EXT_W-1:0] norm;
  logic [5:0]       exp_n, exp_post;
  logic             underflow;
  logic             round_up;
  logic [SIG_W:0]   sig_rnd;
  fp16_t            s2n_res;
  logic             s2n_ovf;

  logic             s2_valid;
  fp16_t            s2_res;
  logic             s2_ovf;

  assign sign_a  = op_a.sign;
  assign sign_b  = op_b.sign ^ op_sub;
  assign eff_sub = sign_a ^ sign_b;

  assign nan_a = (op_a.exp == 5'h1f) && (op_a.frac != '0);
  assign nan_b = (op_b.exp == 5'h1f) && (op_b.frac != '0);
  assign inf_a = (op_a.exp == 5'h1f) && (op_a.frac == '0);
  assign inf_b = (op_b.exp == 5'h1f) && (op_b.frac == '0);

  always_comb begin
    s1n_special     = 1'b1;
    s1n_special_res = QNAN;
    if (nan_a || nan_b) begin
      s1n_special_res = QNAN;
    end else if (inf_a && inf_b) begin
      // Opposite infinities cancel into NaN
      s1n_special_res = eff_sub ? QNAN : inf_of(sign_a);
    end else if (inf_a) begin
      s1n_special_res = inf_of(sign_a);
    end else if (inf_b) begin
      s1n_special_res = inf_of(sign_b);
    end else begin
      s1n_special = 1'b0;
    end
  end

  // DAZ, a zero exponent means a zero significand
  assign m_a = (op_a.exp == '0) ? '0 : {1'b1, op_a.frac};
  assign m_b = (op_b.exp == '0) ? '0 : {1'b1, op_b.frac};

  // Larger magnitude goes first
  assign swap    = (op_b.exp > op_a.exp) || ((op_b.exp == op_a.exp) && (m_b > m_a));
  assign e_big   = swap ? op_b.exp : op_a.exp;
  assign e_small = swap ? op_a.exp : op_b.exp;
  assign e_diff  = e_big - e_small;
  assign x_big   = {swap ? m_b : m_a, {GRS_W{1'b0}}};
  assign x_small = {swap ? m_a : m_b, {GRS_W{1'b0}}};

  // Align with sticky collecting every bit shifted out
  assign x_shift = x_small >> e_diff;
  assign sticky  = |(x_small & ~({EXT_W{1'b1}} << e_diff));
  assign x_align = {x_shift[EXT_W-1:1], x_shift[0] | sticky};

  assign s1n_mag = eff_sub ? ({1'b0, x_big} - {1'b0, x_align})
                           : ({1'b0, x_big} + {1'b0, x_align});

  always_ff @(posedge CLK or negedge nRST) begin
    if (!nRST) begin
      s1_valid <= 1'b0;
    end else begin
      s1_valid <= in_valid;
    end
  end

  always_ff @(posedge CLK) begin
    if (in_valid) begin
      s1_special     <= s1n_special;
      s1_special_res <= s1n_special_res;
      s1_mag         <= s1n_mag;
      s1_exp         <= e_big;
      s1_sign        <= swap ? sign_b : sign_a;
    end
  end

  assign lz = lzc(s1_mag[EXT_W-1:0]);

  always_comb begin
    underflow = 1'b0;
    if (s1_mag[SUM_W-1]) begin
      // Carry out, shift right once and fold the lost bit into sticky
      norm  = {s1_mag[SUM_W-1:2], s1_mag[1] | s1_mag[0]};
      exp_n = {1'b0, s1_exp} + 6'd1;
    end else begin
      norm      = s1_mag[EXT_W-1:0] << lz;
      exp_n     = {1'b0, s1_exp} - {2'b00, lz};
      underflow = ({1'b0, s1_exp} <= {2'b00, lz});
    end
  end

  // Round to nearest, ties to even
  assign round_up = norm[2] & (norm[1] | norm[0] | norm[3]);
  assign sig_rnd  = {1'b0, norm[EXT_W-1:GRS_W]} + 12'(round_up);
  assign exp_post = exp_n + 6'(sig_rnd[SIG_W]);

  always_comb begin
    s2n_res = '0;
    s2n_ovf = 1'b0;
    if (s1_special) begin
      s2n_res = s1_special_res;
    end else if ((s1_mag == '0) || underflow) begin
      // Cancellation and would-be subnormals give +0
      s2n_res = '0;
    end else if (exp_post >= 6'd31) begin
      s2n_res = inf_of(s1_sign);
      s2n_ovf = 1'b1;
    end else begin
      s2n_res = fp16_t'({s1_sign, exp_post[4:0], sig_rnd[9:0]});
    end
  end

  always_ff @(posedge CLK or negedge nRST) begin
    if (!nRST) begin
      s2_valid <= 1'b0;
    end else begin
      s2_valid <= s1_valid;
    end
  end

  always_ff @(posedge CLK) begin
    if (s1_valid) begin
      s2_res <= s2n_res;
      s2_ovf <= s2n_ovf;
    end
  end

  assign out_valid = s2_valid;
  assign result    = s2_valid ? s2_res : '0;
  assign overflow  = s2_valid & s2_ovf;

endmodule

`default_nettype wire

// ==== vec_ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none

module vec_ctrl
  import vec_pkg::*;
#(
  parameter int VLEN = 8
) (
  input  logic CLK,
  input  logic nRST,
  input  logic start_pulse,
  input  logic issue_last,
  input  logic retire_last,
  input  logic out_valid,
  output logic busy,
  output logic clear,
  output logic issue_en,
  output logic done_set
);

  vec_state_t state, state_nxt;

  // Lane index is only 4 bits wide
  if ((VLEN < 1) || (VLEN > 16)) begin : g_vlen_check
    $error("VLEN out of range 1 to 16");
  end

  always_ff @(posedge CLK or negedge nRST) begin
    if (!nRST) begin
      state <= ST_IDLE;
    end else begin
      state <= state_nxt;
    end
  end

  always_comb begin
    state_nxt = state;
    case (state)
      ST_IDLE:  if (start_pulse) state_nxt = ST_ISSUE;
      ST_ISSUE: if (issue_last) state_nxt = ST_DRAIN;
      // Wait for the last lane to leave the pipeline
      ST_DRAIN: if (out_valid && retire_last) state_nxt = ST_DONE;
      ST_DONE:  state_nxt = ST_IDLE;
      default:  state_nxt = ST_IDLE;
    endcase
  end

  assign busy     = state != ST_IDLE;
  assign clear    = (state == ST_IDLE) & start_pulse;
  assign issue_en = state == ST_ISSUE;
  assign done_set = state == ST_DONE;

endmodule

`default_nettype wire

// ==== vec_elem_counter.sv ====
`timescale 1ns/1ps
`default_nettype none

module vec_elem_counter
  import vec_pkg::*;
#(
  parameter int VLEN = 8
) (
  input  logic  CLK,
  input  logic  nRST,
  input  logic  clear,
  input  logic  issue_en,
  input  logic  out_valid,
  output lane_t issue_idx,
  output lane_t retire_idx,
  output logic  issue_last,
  output logic  retire_last
);

  localparam lane_t LAST = lane_t'(VLEN - 1);

  assign issue_last  = issue_idx == LAST;
  assign retire_last = retire_idx == LAST;

  // Issue side runs ahead of retire by the pipeline depth
  always_ff @(posedge CLK or negedge nRST) begin
    if (!nRST) begin
      issue_idx <= '0;
    end else if (clear) begin
      issue_idx <= '0;
    end else if (issue_en) begin
      issue_idx <= issue_last ? '0 : issue_idx + lane_t'(1);
    end
  end

  always_ff @(posedge CLK or negedge nRST) begin
    if (!nRST) begin
      retire_idx <= '0;
    end else if (clear) begin
      retire_idx <= '0;
    end else if (out_valid) begin
      retire_idx <= retire_last ? '0 : retire_idx + lane_t'(1);
    end
  end

endmodule

`default_nettype wire

// ==== vec_pkg.sv ====
`default_nettype none

package vec_pkg;

  // Field widths of an fp16 number
  typedef logic [4:0]  exp_t;
  typedef logic [10:0] sig_t;

  typedef logic [7:0]  apb_addr_t;
  typedef logic [31:0] apb_data_t;

  // Lane index, at most 16 lanes
  typedef logic [3:0]  lane_t;

  typedef struct packed {
    logic       sign;
    exp_t       exp;
    logic [9:0] frac;
  } fp16_t;

  typedef struct packed {
    logic      psel;
    logic      penable;
    logic      pwrite;
    apb_addr_t paddr;
    apb_data_t pwdata;
  } apb_req_t;

  typedef struct packed {
    apb_data_t prdata;
    logic      pready;
    logic      pslverr;
  } apb_rsp_t;

  typedef enum logic [1:0] {ST_IDLE, ST_ISSUE, ST_DRAIN, ST_DONE} vec_state_t;

  // Register map
  localparam apb_addr_t ADDR_CTRL   = 8'h00;
  localparam apb_addr_t ADDR_STATUS = 8'h04;
  localparam apb_addr_t ADDR_A_BASE = 8'h40;
  localparam apb_addr_t ADDR_B_BASE = 8'h80;
  localparam apb_addr_t ADDR_C_BASE = 8'hC0;

endpackage

`default_nettype wire

// ==== vec_regfile.sv ====
`timescale 1ns/1ps
`default_nettype none

module vec_regfile
  import vec_pkg::*;
#(
  parameter int VLEN = 8
) (
  input  logic     CLK,
  input  logic     nRST,
  input  apb_req_t apb_req,
  output apb_rsp_t apb_rsp,
  input  logic     busy,
  input  logic     done_set,
  input  lane_t    issue_idx,
  input  lane_t    retire_idx,
  input  logic     out_valid,
  input  fp16_t    result,
  input  logic     overflow,
  output logic     start_pulse,
  output logic     op_sub,
  output fp16_t    op_a,
  output fp16_t    op_b
);

  localparam int IW = (VLEN > 1) ? $clog2(VLEN) : 1;

  fp16_t a_mem [VLEN];
  fp16_t b_mem [VLEN];
  fp16_t c_mem [VLEN];
  logic  done, ovf_sticky;
  logic  access, lane_ok, mapped, err, wr_ok;
  logic  is_ctrl, is_status, is_a, is_b, is_c;
  lane_t lane;

  assign access  = apb_req.psel & apb_req.penable;
  assign lane    = apb_req.paddr[5:2];
  assign lane_ok = (int'(lane) < VLEN) && (apb_req.paddr[1:0] == 2'b00);

  assign is_ctrl   = apb_req.paddr == ADDR_CTRL;
  assign is_status = apb_req.paddr == ADDR_STATUS;
  assign is_a      = (apb_req.paddr[7:6] == ADDR_A_BASE[7:6]) && lane_ok;
  assign is_b      = (apb_req.paddr[7:6] == ADDR_B_BASE[7:6]) && lane_ok;
  assign is_c      = (apb_req.paddr[7:6] == ADDR_C_BASE[7:6]) && lane_ok;
  assign mapped    = is_ctrl | is_status | is_a | is_b | is_c;

  // C and STATUS are read only, the rest is locked during a run
  assign err   = !mapped
               | (apb_req.pwrite & (is_status | is_c))
               | (apb_req.pwrite & busy & (is_ctrl | is_a | is_b));
  assign wr_ok = access & apb_req.pwrite & !err;

  assign start_pulse = wr_ok & is_ctrl & apb_req.pwdata[0];

  assign op_a = a_mem[issue_idx[IW-1:0]];
  assign op_b = b_mem[issue_idx[IW-1:0]];

  always_comb begin
    apb_rsp.prdata  = '0;
    apb_rsp.pready  = 1'b1;
    apb_rsp.pslverr = access & err;
    if (is_ctrl) begin
      apb_rsp.prdata = {30'd0, op_sub, 1'b0};
    end else if (is_status) begin
      apb_rsp.prdata = {29'd0, ovf_sticky, done, busy};
    end else if (is_a) begin
      apb_rsp.prdata = {16'd0, a_mem[lane[IW-1:0]]};
    end else if (is_b) begin
      apb_rsp.prdata = {16'd0, b_mem[lane[IW-1:0]]};
    end else if (is_c) begin
      apb_rsp.prdata = {16'd0, c_mem[lane[IW-1:0]]};
    end
  end

  always_ff @(posedge CLK or negedge nRST) begin
    if (!nRST) begin
      for (int i = 0; i < VLEN; i++) begin
        a_mem[i] <= '0;
        b_mem[i] <= '0;
        c_mem[i] <= '0;
      end
      op_sub     <= 1'b0;
      done       <= 1'b0;
      ovf_sticky <= 1'b0;
    end else begin
      if (wr_ok && is_a) begin
        a_mem[lane[IW-1:0]] <= fp16_t'(apb_req.pwdata[15:0]);
      end
      if (wr_ok && is_b) begin
        b_mem[lane[IW-1:0]] <= fp16_t'(apb_req.pwdata[15:0]);
      end
      if (wr_ok && is_ctrl) begin
        op_sub <= apb_req.pwdata[1];
      end
      // Results retire in lane order
      if (out_valid) begin
        c_mem[retire_idx[IW-1:0]] <= result;
      end
      if (start_pulse) begin
        done       <= 1'b0;
        ovf_sticky <= 1'b0;
      end else begin
        if (done_set) begin
          done <= 1'b1;
        end
        if (out_valid && overflow) begin
          ovf_sticky <= 1'b1;
        end
      end
    end
  end

endmodule

`default_nettype wire

// ==== vec_unit_asserts.sv ====
`timescale 1ns/1ps
`default_nettype none

module vec_unit_asserts
  import vec_pkg::*;
(
  input logic  CLK,
  input logic  nRST,
  input logic  in_valid,
  input logic  busy,
  input logic  done_set,
  input logic  out_valid,
  input fp16_t result
);

  // Fixed two-stage latency
  a_latency: assert property (@(posedge CLK) disable iff (!nRST)
    out_valid == $past(in_valid, 2))
    else $error("out_valid does not follow in_valid by two cycles");

  a_issue_busy: assert property (@(posedge CLK) disable iff (!nRST) in_valid |-> busy)
    else $error("issue_en high while the controller is idle");

  a_done_pulse: assert property (@(posedge CLK) disable iff (!nRST) done_set |=> !done_set)
    else $error("done_set held for more than one cycle");

  a_result_zero: assert property (@(posedge CLK) disable iff (!nRST)
    !out_valid |-> (result == '0))
    else $error("result nonzero while out_valid is low");

endmodule

bind vec_unit_top vec_unit_asserts vec_unit_asserts_inst (
  .CLK(CLK), .nRST(nRST), .in_valid(issue_en), .busy(busy),
  .done_set(done_set), .out_valid(out_valid), .result(result)
);

`default_nettype wire

// ==== vec_unit_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module vec_unit_top
  import vec_pkg::*;
#(
  parameter int VLEN = 8
) (
  input  logic     CLK,
  input  logic     nRST,
  input  apb_req_t apb_req,
  output apb_rsp_t apb_rsp
);

  logic  start_pulse, op_sub;
  logic  busy, clear, issue_en, done_set;
  logic  issue_last, retire_last;
  logic  out_valid, overflow;
  lane_t issue_idx, retire_idx;
  fp16_t op_a, op_b, result;

  vec_regfile #(.VLEN(VLEN)) vec_regfile_inst (
    .CLK(CLK), .nRST(nRST),
    .apb_req(apb_req), .apb_rsp(apb_rsp),
    .busy(busy), .done_set(done_set),
    .issue_idx(issue_idx), .retire_idx(retire_idx),
    .out_valid(out_valid), .result(result), .overflow(overflow),
    .start_pulse(start_pulse), .op_sub(op_sub),
    .op_a(op_a), .op_b(op_b)
  );

  vec_ctrl #(.VLEN(VLEN)) vec_ctrl_inst (
    .CLK(CLK), .nRST(nRST),
    .start_pulse(start_pulse), .issue_last(issue_last),
    .retire_last(retire_last), .out_valid(out_valid),
    .busy(busy), .clear(clear), .issue_en(issue_en), .done_set(done_set)
  );

  vec_elem_counter #(.VLEN(VLEN)) vec_elem_counter_inst (
    .CLK(CLK), .nRST(nRST),
    .clear(clear), .issue_en(issue_en), .out_valid(out_valid),
    .issue_idx(issue_idx), .retire_idx(retire_idx),
    .issue_last(issue_last), .retire_last(retire_last)
  );

  // One lane enters the pipeline per issue cycle
  vaddsub vaddsub_inst (
    .CLK(CLK), .nRST(nRST),
    .in_valid(issue_en), .op_a(op_a), .op_b(op_b), .op_sub(op_sub),
    .out_valid(out_valid), .result(result), .overflow(overflow)
  );

endmodule

`default_nettype wire
